// ==== include/rsa_defines.svh ====
`ifndef RSA_DEFINES_SVH
`define RSA_DEFINES_SVH

// operand width in bits
`define RSA_OPER_WIDTH 256

// width of one load or read word on the host side
`define RSA_IO_WIDTH 64

// width of the limb handled by the serial adder per cycle
`define RSA_LIMB_WIDTH 32

// bit count of an operand needs log2(256)+1 bits
`define RSA_LEN_WIDTH 9

// counts the 8 limbs of one operand
`define RSA_LIMB_CNT_WIDTH 3

`endif

// ==== hw/rsaPkg.sv ====
`default_nettype none
`include "rsa_defines.svh"

package rsaPkg;

	typedef logic [`RSA_OPER_WIDTH-1:0]     operandT; // full operand
	typedef logic [`RSA_IO_WIDTH-1:0]       ioWordT;  // host word
	typedef logic [`RSA_LIMB_WIDTH-1:0]     limbT;    // adder limb
	typedef logic [`RSA_LEN_WIDTH-1:0]      bitLenT;  // used-bit count
	typedef logic [`RSA_LIMB_CNT_WIDTH-1:0] limbIdxT; // limb position

	// exponentiation sequencer
	typedef enum logic [4:0] {
		sIdle, sLenE, sChkE, sLenM, sBitE,                  // setup
		sMulBit, sMulAdd, sMulCmp, sMulSub, sMulDbl, sMulRed, // R = R*M mod N
		sMulRedW,                                             // tmp - N running
		sSqBit, sSqLoop, sSqAdd, sSqCmp, sSqSub, sSqDbl, sSqRed, // M = M*M mod N
		sSqRedW                                               // tmp - N running
	} ctrlStateT;

endpackage

`default_nettype wire

// ==== hw/bitLength.sv ====
`timescale 1ns/10ps
`default_nettype none

// number of used bits in scanWord, top limb down
module bitLength import rsaPkg::*; (
	input  logic    iClk,
	input  logic    M_reset0,
	input  logic    lenStart,
	input  operandT scanWord,
	output bitLenT  bitLen,
	output logic    lenDone
);

	localparam int LW  = $bits(limbT);
	localparam int LVL = $clog2(LW);   // tree depth
	localparam int CW  = LVL + 1;      // 0 to 32 fits

	logic          active;
	limbIdxT       limbIdx;   // limb under test
	limbT          limb;
	limbT          prefix;    // ones from the top set bit down
	logic [CW-1:0] tree [LW];
	logic [CW-1:0] used;
	logic          stop;

	assign limb = scanWord[limbIdx*LW +: LW];

	always_comb begin
		logic run;
		run = 1'b0;
		for (int i = LW-1; i >= 0; i--) begin
			run       = run | limb[i];
			prefix[i] = run;
		end
	end

	// popcount of the prefix = position of top set bit + 1
	always_comb begin
		for (int i = 0; i < LW; i++)
			tree[i] = CW'(prefix[i]);
		for (int l = 0; l < LVL; l++)
			for (int i = 0; i < (LW >> (l+1)); i++)
				tree[i] = tree[2*i] + tree[2*i+1];
	end
	assign used = tree[0];

	assign stop = active & ((|limb) | (limbIdx == '0)); // hit or bottom limb

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			active  <= 1'b0;
			limbIdx <= '0;
			lenDone <= 1'b0;
		end else begin
			lenDone <= stop;
			if (lenStart) begin
				active  <= 1'b1;
				limbIdx <= '1; // top limb first
			end else if (stop) active <= 1'b0;
			else if (active) limbIdx <= limbIdx - 1'b1;
		end
	end

	always_ff @(posedge iClk) begin
		if (stop) bitLen <= (bitLenT'(limbIdx) << LVL) + bitLenT'(used); // zero for zero
	end

endmodule

`default_nettype wire

// ==== hw/serialAddSub.sv ====
`timescale 1ns/10ps
`default_nettype none

// A+B or A-B, one limb per cycle, LS limb first
module serialAddSub import rsaPkg::*; (
	input  logic iClk,
	input  logic M_reset0,
	input  logic addStart,
	input  logic addSub, // held for the whole operation
	input  limbT addA,
	input  limbT addB,
	output limbT sumLimb,
	output logic carryOut,
	output logic dataShift,
	output logic addDone
);

	limbIdxT limbCnt; // limb in flight
	logic    carry;   // carry into the next limb
	logic    carryIn;
	limbT    opB;

	assign dataShift = addStart | (|limbCnt);
	assign addDone   = &limbCnt; // last limb this cycle

	assign opB     = addSub ? ~addB : addB; // two's complement subtract
	assign carryIn = addStart ? addSub : carry; // +1 on the first limb of a subtract
	assign {carryOut, sumLimb} = {1'b0, addA} + {1'b0, opB} + {{$bits(limbT){1'b0}}, carryIn};

	always_ff @(posedge iClk) begin
		if (M_reset0) begin
			limbCnt <= '0;
			carry   <= 1'b0;
		end else begin
			if (dataShift) limbCnt <= limbCnt + 1'b1; // wraps to 0 after the top limb
			carry <= carryOut;
		end
	end

endmodule

`default_nettype wire

// ==== hw/operandRegs.sv ====
`timescale 1ns/10ps
`default_nettype none

module operandRegs import rsaPkg::*; (
	input  logic    iClk,
	input  logic    M_reset0,
	input  logic    iWrM, iWrE, iWrN, iRdR,
	input  ioWordT  iM,
	input  ioWordT  iE,
	input  ioWordT  iN,
	input  logic    mClear, mShift, mbinLoad, mbinShift, eShift, nRotate,
	input  logic    rClear, rSetOne, rShift,
	input  logic    tmpGetR, tmpGetM, tmpDouble, tmpRotate, tmpUpdate,
	input  logic [1:0] selA,   // bit0 R, bit1 M, none tmp
	input  logic [1:0] selCmp,
	input  logic    lenSelE,
	input  limbT    sumLimb,
	input  logic    dataShift, // adder consumes a limb this cycle
	output ioWordT  oR,
	output logic    eLsb, mbinLsb, tmpMsb, cmpGeq,
	output limbT    addA,
	output limbT    addB,
	output operandT scanWord
);

	localparam int W   = $bits(operandT);
	localparam int LW  = $bits(limbT);
	localparam int IOW = $bits(ioWordT);

	operandT regM;    // base, squared in place
	operandT regMbin; // multiplier bits, shifted out LSB first
	operandT regE;    // exponent, shifted out LSB first
	operandT regN;    // modulus
	operandT regR;    // result accumulator
	operandT regTmp;  // multiplicand, doubled per step
	operandT cmpOperand;

	always_ff @(posedge iClk) begin
		if (mClear) regM <= '0;
		else if (iWrM) regM <= {iM, regM[W-1:IOW]}; // host word in at the top
		else if (mShift && dataShift) regM <= {sumLimb, regM[W-1:LW]};
	end

	always_ff @(posedge iClk) begin
		if (mbinLoad) regMbin <= regM;
		else if (mbinShift) regMbin <= {1'b0, regMbin[W-1:1]};
	end

	always_ff @(posedge iClk) begin
		if (iWrE) regE <= {iE, regE[W-1:IOW]};
		else if (eShift) regE <= {1'b0, regE[W-1:1]};
	end

	always_ff @(posedge iClk) begin
		if (iWrN) regN <= {iN, regN[W-1:IOW]};
		else if (nRotate && dataShift) regN <= {regN[LW-1:0], regN[W-1:LW]}; // back in place after 8
	end

	// R reads back zero until the first run
	always_ff @(posedge iClk) begin
		if (M_reset0 || rClear) regR <= '0;
		else if (rSetOne) regR <= operandT'(1);
		else if (iRdR) regR <= {regR[IOW-1:0], regR[W-1:IOW]}; // readout rotation
		else if (rShift && dataShift) regR <= {sumLimb, regR[W-1:LW]};
	end

	always_ff @(posedge iClk) begin
		if (tmpGetR) regTmp <= regR;
		else if (tmpGetM) regTmp <= regM;
		else if (tmpDouble) regTmp <= {regTmp[W-2:0], 1'b0};
		else if (tmpRotate && dataShift) regTmp <= {regTmp[LW-1:0], regTmp[W-1:LW]};
		else if (tmpUpdate && dataShift) regTmp <= {sumLimb, regTmp[W-1:LW]};
	end

	// adder always works on the low limb
	assign addA = selA[0] ? regR[LW-1:0] :
		selA[1] ? regM[LW-1:0] : regTmp[LW-1:0];
	assign addB = nRotate ? regN[LW-1:0] : regTmp[LW-1:0]; // N only while subtracting

	assign cmpOperand = selCmp[0] ? regR :
		selCmp[1] ? regM : regTmp;
	assign cmpGeq = (cmpOperand >= regN);

	assign scanWord = lenSelE ? regE : regM;
	assign eLsb     = regE[0];
	assign mbinLsb  = regMbin[0];
	assign tmpMsb   = regTmp[W-1];
	assign oR       = regR[W-1 -: IOW]; // top word, LS word first after rotation

endmodule

`default_nettype wire

// ==== hw/modExpCtrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module modExpCtrl import rsaPkg::*; (
	input  logic iClk,
	input  logic M_reset0,
	input  logic iStart,
	input  logic lenDone, addDone, carryOut,
	input  logic eLsb, mbinLsb, tmpMsb, cmpGeq,
	input  bitLenT bitLen,
	output logic oDone,
	output logic addStart, addSub,     // addSub 1 = A - B
	output logic lenStart, lenSelE,    // lenSelE 1 = scan E
	output logic mClear, mShift, mbinLoad, mbinShift, eShift, nRotate,
	output logic rClear, rSetOne, rShift,
	output logic tmpGetR, tmpGetM, tmpDouble, tmpRotate, tmpUpdate,
	output logic [1:0] selA,           // bit0 R, bit1 M, none tmp
	output logic [1:0] selCmp          // same coding as selA
);

	ctrlStateT state;
	bitLenT    lenE;     // exponent bits still to go
	bitLenT    lenM;     // multiplier bits left in a square
	bitLenT    lenMR;    // multiplier bits left in a multiply
	logic      overflow; // bit that fell off above the MSB
	logic      geq;

	assign geq = cmpGeq | overflow; // operand >= N once the lost bit counts

	always_ff @(posedge iClk) begin
		oDone     <= 1'b0; // single-cycle strobes
		lenStart  <= 1'b0;
		addStart  <= 1'b0;
		mClear    <= 1'b0;
		mShift    <= 1'b0;
		mbinLoad  <= 1'b0;
		mbinShift <= 1'b0;
		eShift    <= 1'b0;
		nRotate   <= 1'b0;
		rClear    <= 1'b0;
		rSetOne   <= 1'b0;
		rShift    <= 1'b0;
		tmpGetR   <= 1'b0;
		tmpGetM   <= 1'b0;
		tmpDouble <= 1'b0;
		tmpRotate <= 1'b0;
		tmpUpdate <= 1'b0;
		selCmp    <= 2'b00; // compare tmp by default
		if (M_reset0) begin
			state    <= sIdle;
			overflow <= 1'b0;
			lenE     <= '0;
			lenM     <= '0;
			lenMR    <= '0;
			addSub   <= 1'b0;
			selA     <= 2'b00;
			lenSelE  <= 1'b0;
		end else begin
			case (state)
				sIdle: if (iStart) begin
					lenStart <= 1'b1;
					lenSelE  <= 1'b1; // exponent length first
					state    <= sLenE;
				end
				sLenE: if (lenDone) begin
					lenE    <= bitLen;
					rSetOne <= 1'b1; // R starts at 1
					state   <= sChkE;
				end
				sChkE: if (lenE == '0) begin
					oDone <= 1'b1; // all exponent bits consumed
					state <= sIdle;
				end else begin
					lenStart <= 1'b1;
					lenSelE  <= 1'b0; // now the current M
					state    <= sLenM;
				end
				sLenM: if (lenDone) begin
					lenM     <= bitLen;
					lenMR    <= bitLen;
					mbinLoad <= 1'b1; // multiplier bits = M
					state    <= sBitE;
				end
				sBitE: begin
					eShift <= 1'b1; // next exponent bit
					if (eLsb) begin
						tmpGetR <= 1'b1; // tmp = R, R accumulates
						rClear  <= 1'b1;
						state   <= sMulBit;
					end else begin
						mbinLoad <= 1'b1; // straight to squaring
						tmpGetM  <= 1'b1;
						mClear   <= 1'b1;
						state    <= sSqLoop;
					end
				end
				sMulBit: if (lenMR == '0) begin
					mbinLoad <= 1'b1; // multiply done, square M next
					tmpGetM  <= 1'b1;
					mClear   <= 1'b1;
					state    <= sSqLoop;
				end else begin
					mbinShift <= 1'b1;
					if (mbinLsb) begin
						addStart  <= 1'b1; // R += tmp
						addSub    <= 1'b0;
						selA      <= 2'b01;
						rShift    <= 1'b1;
						tmpRotate <= 1'b1;
						state     <= sMulAdd;
					end else begin
						tmpDouble <= 1'b1;
						state     <= sMulDbl;
					end
				end
				sMulAdd: if (addDone) begin
					overflow <= carryOut;
					selCmp   <= 2'b01; // check R against N
					state    <= sMulCmp;
				end else begin
					rShift    <= 1'b1;
					tmpRotate <= 1'b1;
				end
				sMulCmp: begin
					overflow <= 1'b0;
					if (geq) begin
						addStart <= 1'b1; // R -= N
						addSub   <= 1'b1;
						selA     <= 2'b01;
						rShift   <= 1'b1;
						nRotate  <= 1'b1;
						state    <= sMulSub;
					end else begin
						tmpDouble <= 1'b1;
						state     <= sMulDbl;
					end
				end
				sMulSub: if (addDone) begin
					tmpDouble <= 1'b1;
					state     <= sMulDbl;
				end else begin
					rShift  <= 1'b1;
					nRotate <= 1'b1;
				end
				sMulDbl: begin
					overflow <= tmpMsb; // MSB leaves tmp this cycle
					state    <= sMulRed;
				end
				sMulRed: begin
					overflow <= 1'b0;
					if (geq) begin
						addStart  <= 1'b1; // tmp -= N
						addSub    <= 1'b1;
						selA      <= 2'b00;
						tmpUpdate <= 1'b1;
						nRotate   <= 1'b1;
						state     <= sMulRedW;
					end else begin
						lenMR <= lenMR - 1'b1;
						state <= sMulBit;
					end
				end
				sMulRedW: if (addDone) begin
					lenMR <= lenMR - 1'b1;
					state <= sMulBit;
				end else begin
					tmpUpdate <= 1'b1;
					nRotate   <= 1'b1;
				end
				sSqLoop: if (lenM == '0) begin
					lenE  <= lenE - 1'b1; // one exponent bit done
					state <= sChkE;
				end else begin
					state <= sSqBit;
				end
				sSqBit: begin
					mbinShift <= 1'b1;
					if (mbinLsb) begin
						addStart  <= 1'b1; // M += tmp
						addSub    <= 1'b0;
						selA      <= 2'b10;
						mShift    <= 1'b1;
						tmpRotate <= 1'b1;
						state     <= sSqAdd;
					end else begin
						tmpDouble <= 1'b1;
						state     <= sSqDbl;
					end
				end
				sSqAdd: if (addDone) begin
					overflow <= carryOut;
					selCmp   <= 2'b10; // check M against N
					state    <= sSqCmp;
				end else begin
					mShift    <= 1'b1;
					tmpRotate <= 1'b1;
				end
				sSqCmp: begin
					overflow <= 1'b0;
					if (geq) begin
						addStart <= 1'b1; // M -= N
						addSub   <= 1'b1;
						selA     <= 2'b10;
						mShift   <= 1'b1;
						nRotate  <= 1'b1;
						state    <= sSqSub;
					end else begin
						tmpDouble <= 1'b1;
						state     <= sSqDbl;
					end
				end
				sSqSub: if (addDone) begin
					tmpDouble <= 1'b1;
					state     <= sSqDbl;
				end else begin
					mShift  <= 1'b1;
					nRotate <= 1'b1;
				end
				sSqDbl: begin
					overflow <= tmpMsb;
					state    <= sSqRed;
				end
				sSqRed: begin
					overflow <= 1'b0;
					if (geq) begin
						addStart  <= 1'b1; // tmp -= N
						addSub    <= 1'b1;
						selA      <= 2'b00;
						tmpUpdate <= 1'b1;
						nRotate   <= 1'b1;
						state     <= sSqRedW;
					end else begin
						lenM  <= lenM - 1'b1;
						state <= sSqLoop;
					end
				end
				sSqRedW: if (addDone) begin
					lenM  <= lenM - 1'b1;
					state <= sSqLoop;
				end else begin
					tmpUpdate <= 1'b1;
					nRotate   <= 1'b1;
				end
				default: state <= sIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/rsaModExp.sv ====
`timescale 1ns/10ps
`default_nettype none

// R = M^E mod N, right-to-left square and multiply
module rsaModExp import rsaPkg::*; (
	input  logic   iClk,
	input  logic   M_reset0,
	input  logic   iStart,
	input  logic   iWrM,
	input  logic   iWrE,
	input  logic   iWrN,
	input  logic   iRdR,
	input  ioWordT iM,
	input  ioWordT iE,
	input  ioWordT iN,
	output ioWordT oR,
	output logic   oDone
);

	// register strobes, all from the sequencer
	logic mClear, mShift, mbinLoad, mbinShift, eShift, nRotate;
	logic rClear, rSetOne, rShift;
	logic tmpGetR, tmpGetM, tmpDouble, tmpRotate, tmpUpdate;
	logic [1:0] selA;   // adder A operand
	logic [1:0] selCmp; // operand compared against N

	// status back to the sequencer
	logic eLsb, mbinLsb, tmpMsb, cmpGeq;

	// serial adder
	logic addStart, addSub, addDone, carryOut, dataShift;
	limbT addA;
	limbT addB;
	limbT sumLimb;

	// bit-length scanner
	logic    lenStart, lenSelE, lenDone;
	operandT scanWord;
	bitLenT  bitLen;

	// names match port for port across the blocks
	modExpCtrl ctrl_i (.*);

	operandRegs regs_i (.*);

	serialAddSub addSub_i (.*);

	bitLength len_i (.*);

endmodule

`default_nettype wire

// ==== tb/tbRsaModExp.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbRsaModExp import rsaPkg::*; ();

	localparam int IOW     = $bits(ioWordT);
	localparam int WORDS   = $bits(operandT) / IOW; // host words per operand
	localparam int TIMEOUT = 2000000;                // cycles allowed per run

	logic   iClk;
	logic   M_reset0;
	logic   iStart;
	logic   iWrM, iWrE, iWrN, iRdR;
	ioWordT iM, iE, iN;
	ioWordT oR;
	logic   oDone;

	int      fd;
	string   line;       // raw stim line
	string   name;
	operandT stimM, stimE, stimN, stimR;
	int      fields;
	int      testCount;
	int      failCount;
	int      errorCount; // value mismatches over the run
	int      errorsBefore;
	bit      finished;
	bit      timedOut;

	rsaModExp dut_i (.*);

	always #50 iClk = ~iClk; // 100 ns period

	task automatic checkValue(input string label, input operandT expected, input operandT actual);
		if (expected !== actual) begin
			$display("ERROR %0s expected %h actual %h", label, expected, actual);
			errorCount++;
		end
	endtask

	// all three registers shift in parallel, LS word first
	task automatic loadOperands(input operandT m, input operandT e, input operandT n);
		for (int i = 0; i < WORDS; i++) begin
			@(posedge iClk);
			iWrM <= 1'b1;
			iWrE <= 1'b1;
			iWrN <= 1'b1;
			iM   <= m[i*IOW +: IOW];
			iE   <= e[i*IOW +: IOW];
			iN   <= n[i*IOW +: IOW];
		end
		@(posedge iClk);
		iWrM <= 1'b0;
		iWrE <= 1'b0;
		iWrN <= 1'b0;
	endtask

	task automatic startRun();
		@(posedge iClk);
		iStart <= 1'b1; // one-cycle pulse
		@(posedge iClk);
		iStart <= 1'b0;
	endtask

	task automatic waitDone(output bit done);
		done = 1'b0;
		for (int n = 0; n < TIMEOUT && !done; n++) begin
			@(negedge iClk);
			done = oDone; // mid-cycle, away from the edge
		end
	endtask

	// each pulse rotates R right by one word, oR shows the top word
	task automatic readResult(output operandT r);
		r = '0;
		for (int i = 0; i < WORDS; i++) begin
			@(posedge iClk);
			iRdR <= 1'b1;
			@(posedge iClk);
			iRdR <= 1'b0; // rotation happens on this edge
			@(posedge iClk);
			r[i*IOW +: IOW] = oR;
		end
	endtask

	task automatic runVector();
		operandT firstRead;
		operandT secondRead;
		bit      done;
		fields = $sscanf(line, "%s %h %h %h %h", name, stimM, stimE, stimN, stimR);
		if (fields != 5) begin
			$display("stimulus line could not be parsed: %0s", line);
			failCount++;
		end else begin
			testCount++;
			errorsBefore = errorCount;
			loadOperands(stimM, stimE, stimN); // no reset between tests
			startRun();
			waitDone(done);
			if (!done) begin
				$display("test %0s did not finish within %0d cycles", name, TIMEOUT);
				failCount++;
				timedOut = 1'b1;
			end else begin
				readResult(firstRead);
				checkValue(name, stimR, firstRead);
				readResult(secondRead); // R is back in place after 4 pulses
				checkValue({name, " reread"}, stimR, secondRead);
				if (errorCount == errorsBefore) begin
					$display("test %0s passed", name);
				end else begin
					$display("test %0s failed", name);
					failCount++;
				end
			end
		end
	endtask

	initial begin
		iClk       = 1'b0;
		M_reset0   = 1'b1;
		iStart     = 1'b0;
		iWrM       = 1'b0;
		iWrE       = 1'b0;
		iWrN       = 1'b0;
		iRdR       = 1'b0;
		iM         = '0;
		iE         = '0;
		iN         = '0;
		testCount  = 0;
		failCount  = 0;
		errorCount = 0;
		finished   = 1'b0;
		timedOut   = 1'b0;
		repeat (16) @(posedge iClk); // reset held 16 cycles
		M_reset0 <= 1'b0;

		fd = $fopen("tb/rsa_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file tb/rsa_stim.txt");
			failCount++;
		end else begin
			while (!finished && !timedOut) begin
				if ($fgets(line, fd) == 0) finished = 1'b1; // end of file
				else if (line.len() > 1 && line.getc(0) != "#") runVector(); // skip notes
			end
			$fclose(fd);
		end
		if (testCount == 0) begin
			$display("no test vectors were run");
			failCount++;
		end

		$display("%0d tests run, %0d failed, %0d mismatches", testCount, failCount, errorCount);
		if (failCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rsaModExp.f ====
+incdir+include
hw/rsaPkg.sv
hw/bitLength.sv
hw/serialAddSub.sv
hw/operandRegs.sv
hw/modExpCtrl.sv
hw/rsaModExp.sv
tb/tbRsaModExp.sv

// ==== run.sh ====
#!/bin/sh
# compile the RTL and the testbench with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbRsaModExp \
	-f rsaModExp.f -o simRsaModExp || { echo "Verilator build failed"; exit 1; }

# the run counts as passed only if the pass line shows up in the output
out=$(./obj_dir/simRsaModExp) || echo "simulation exited with an error status"
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}

// ==== tb/rsa_stim.txt ====
# one test per line: name, then M, E, N and the expected R = M^E mod N, all in hex
# preconditions per line: M < N, N >= 2, N below 2^255
small_4_13_497 4 d 1f1 1bd
exp_zero 5 0 7 1
exp_one 0123456789abcdeffedcba9876543210 1 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 0123456789abcdeffedcba9876543210
wide_neg_one 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 100000000000000010000000000000003 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec
m_zero 0 5 b 0
small_7_10_13 7 a d 4
small_3_205_1000 3 cd 3e8 f3
pow2_wide 4000000000000000000000000000000000000000000000000000000000000000 10000000000000005 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0200000000000000000000000000000000000000000000000000000000000000
